//--- tb.f
miss_pkg.sv
miss_intake.sv
mshr_file.sv
fill_fetcher.sv
fill_return.sv
miss_unit_top.sv
tb_wb_mem.sv
tb_miss_unit.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove obj_dir and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_miss_unit -f tb.f -o sim_tb
	./obj_dir/sim_tb > $(LOG)
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation reported errors"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- tb_miss_unit.sv
module tb_miss_unit
    import miss_pkg::*;
();

    localparam int LINE_W       = WORD_W * (1 << LINE_WORDS_LOG);
    localparam int ACCEPT_LIMIT = 200;
    localparam int DRAIN_LIMIT  = 600;

    typedef struct packed {
        logic [3:0]             test;
        logic [BYTE_ADDR_W-1:0] addr;
        logic [SLOT_IDX_W-1:0]  slot;
        req_kind_t              kind;
        logic [3:0]             gap;     // idle cycles before the request.
        logic                   stall;   // memory acks held off.
    } row_t;

    logic                   clk;
    logic                   reset;
    logic                   req_valid;
    logic                   req_ready;
    logic [BYTE_ADDR_W-1:0] req_addr;
    logic [SLOT_IDX_W-1:0]  req_slot;
    req_kind_t              req_kind;
    logic                   mem_stall;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic                   wb_ack;
    logic [BYTE_ADDR_W-1:0] wb_adr;
    logic [WORD_W/8-1:0]    wb_sel;
    logic [WORD_W-1:0]      wb_dat;
    logic                   wake_valid;
    logic [LINE_ADDR_W-1:0] wake_addr;
    logic [LINE_W-1:0]      wake_data;
    logic [SLOT_COUNT-1:0]  wake_rd_slots;
    logic [SLOT_COUNT-1:0]  wake_sw_slots;

    // model of the outstanding lines in allocation order.
    logic [LINE_ADDR_W-1:0] q_addr[$];
    logic [SLOT_COUNT-1:0]  q_rd[$];
    logic [SLOT_COUNT-1:0]  q_sw[$];
    logic                   pend_valid = 1'b0;
    logic [LINE_ADDR_W-1:0] pend_line;
    logic [SLOT_COUNT-1:0]  pend_rd;
    logic [SLOT_COUNT-1:0]  pend_sw;
    logic                   ack_seen = 1'b0;

    row_t  rows[$];
    string test_names[6] = '{"reset_state", "single_load", "merge_same_line",
                             "distinct_order", "full_stall", "wake_cycle_alloc"};
    string test_name = "reset_state";
    int    errors = 0;
    int    checks = 0;
    int    tests_run = 0;
    int    passed = 0;
    int    errors_mark = 0;
    int    same_cycle_allocs = 0;
    logic  aborted = 1'b0;

    miss_unit_top #(.MSHR_DEPTH(8)) uut (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_addr(req_addr), .req_slot(req_slot),
        .req_kind(req_kind), .req_ready(req_ready),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_sel(wb_sel), .wb_dat_i(wb_dat), .wb_ack(wb_ack),
        .wake_valid(wake_valid), .wake_addr(wake_addr), .wake_data(wake_data),
        .wake_rd_slots(wake_rd_slots), .wake_sw_slots(wake_sw_slots)
    );

    tb_wb_mem mem (
        .clk(clk), .reset(reset), .mem_stall(mem_stall),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_o(wb_dat), .wb_ack(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [SLOT_COUNT-1:0] one_hot(input logic [SLOT_IDX_W-1:0] slot);
        return SLOT_COUNT'(1) << slot;
    endfunction

    // expected line from the memory rule with word 0 in the low bits.
    function automatic logic [LINE_W-1:0] line_data(input logic [LINE_ADDR_W-1:0] line);
        logic [LINE_W-1:0]      data;
        logic [BYTE_ADDR_W-1:0] adr;
        for (int w = 0; w < (1 << LINE_WORDS_LOG); w++) begin
            adr = {line, LINE_WORDS_LOG'(w), 2'b00};
            data[w*WORD_W +: WORD_W] = WORD_W'(adr) * 3 + 1;
        end
        return data;
    endfunction

    task automatic compare_value(input string what, input logic [LINE_W-1:0] expected,
                                 input logic [LINE_W-1:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic add_row(input int test, input logic [BYTE_ADDR_W-1:0] addr,
                           input int slot, input req_kind_t kind, input int gap,
                           input logic stall);
        rows.push_back(row_t'{4'(test), addr, SLOT_IDX_W'(slot), kind, 4'(gap), stall});
    endtask

    task automatic build_table();
        add_row(1, 15'h0120, 3, REQ_LOAD, 0, 1'b0);
        add_row(2, 15'h0450, 1, REQ_LOAD, 0, 1'b0);
        add_row(2, 15'h0454, 5, REQ_STORE, 0, 1'b0);
        add_row(2, 15'h045c, 6, REQ_LOAD, 1, 1'b0);
        add_row(2, 15'h0458, 2, REQ_STORE, 0, 1'b0);
        add_row(3, 15'h1000, 0, REQ_LOAD, 0, 1'b0);
        add_row(3, 15'h2340, 1, REQ_STORE, 2, 1'b0);
        add_row(3, 15'h0ff0, 2, REQ_LOAD, 0, 1'b0);
        add_row(3, 15'h2348, 4, REQ_LOAD, 0, 1'b0);   // joins 0x2340.
        add_row(3, 15'h7ff0, 7, REQ_LOAD, 3, 1'b0);
        for (int k = 0; k < 9; k++) begin
            add_row(4, 15'('h3000 + k * 'h10), k, (k % 2 == 0) ? REQ_LOAD : REQ_STORE, 0, 1'b1);
        end
        // back to back on one line, so one request lands in the wake cycle.
        for (int k = 0; k < 32; k++) begin
            add_row(5, 15'('h05a0 + (k % 4) * 4), k, (k % 2 == 0) ? REQ_STORE : REQ_LOAD, 0, 1'b0);
        end
    endtask

    task automatic send_row(input row_t r);
        int waited;
        if (r.gap != 0) begin
            req_valid <= 1'b0;
            repeat (r.gap) @(posedge clk);
        end
        mem_stall <= r.stall;
        req_valid <= 1'b1;
        req_addr  <= r.addr;
        req_slot  <= r.slot;
        req_kind  <= r.kind;
        waited = 0;
        @(negedge clk);
        while (!req_ready && waited < ACCEPT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!req_ready) begin
            $display("timeout: request for address %h was never accepted", r.addr);
            errors++;
            aborted = 1'b1;
        end
        @(posedge clk);
    endtask

    task automatic drain_wakes();
        int waited;
        if (mem_stall) begin
            repeat (4) @(negedge clk);
            compare_value("req_ready while full", LINE_W'(1'b0), LINE_W'(req_ready));
            @(posedge clk);
            mem_stall <= 1'b0;
        end
        waited = 0;
        while ((q_addr.size() != 0 || pend_valid) && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (q_addr.size() != 0 || pend_valid) begin
            $display("timeout: %0d lines of %s never got a wake", q_addr.size(), test_name);
            errors++;
            aborted = 1'b1;
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == errors_mark) begin
            passed++;
            $display("test %s ok", test_name);
        end else begin
            $display("test %s failed with %0d errors", test_name, errors - errors_mark);
        end
        errors_mark = errors;
        same_cycle_allocs = 0;
    endtask

    // outputs are stable at the falling edge; wakes are handled before placements.
    always @(negedge clk) begin : model
        logic found;
        if (reset === 1'b0) begin
            if (wake_valid) begin
                if (q_addr.size() == 0) begin
                    $display("%s: wake for line %h with no miss outstanding", test_name, wake_addr);
                    errors++;
                end else begin
                    compare_value("wake_addr", LINE_W'(q_addr[0]), LINE_W'(wake_addr));
                    compare_value("wake_data", line_data(q_addr[0]), wake_data);
                    compare_value("wake_rd_slots", LINE_W'(q_rd[0]), LINE_W'(wake_rd_slots));
                    compare_value("wake_sw_slots", LINE_W'(q_sw[0]), LINE_W'(wake_sw_slots));
                    void'(q_addr.pop_front());
                    void'(q_rd.pop_front());
                    void'(q_sw.pop_front());
                end
            end
            if (pend_valid && req_ready) begin
                found = 1'b0;
                if (wake_valid && pend_line == wake_addr) begin
                    same_cycle_allocs++;
                end
                foreach (q_addr[k]) begin
                    if (q_addr[k] == pend_line) begin
                        q_rd[k] = q_rd[k] | pend_rd;
                        q_sw[k] = q_sw[k] | pend_sw;
                        found = 1'b1;
                    end
                end
                if (!found) begin
                    q_addr.push_back(pend_line);
                    q_rd.push_back(pend_rd);
                    q_sw.push_back(pend_sw);
                end
                pend_valid = 1'b0;
            end
            if (req_valid && req_ready) begin
                pend_valid = 1'b1;
                pend_line  = req_addr[BYTE_ADDR_W-1 -: LINE_ADDR_W];
                pend_rd    = (req_kind == REQ_LOAD) ? one_hot(req_slot) : '0;
                pend_sw    = (req_kind == REQ_STORE) ? one_hot(req_slot) : '0;
            end
        end
    end

    // each read beat keeps cyc with stb and all byte lanes, and stb falls after its ack.
    always @(negedge clk) begin : bus_rules
        if (reset === 1'b0) begin
            if (ack_seen) begin
                compare_value("wb_stb after ack", LINE_W'(1'b0), LINE_W'(wb_stb));
            end
            if (wb_stb) begin
                compare_value("wb_cyc with stb", LINE_W'(1'b1), LINE_W'(wb_cyc));
                compare_value("wb_we", LINE_W'(1'b0), LINE_W'(wb_we));
                compare_value("wb_sel", LINE_W'({(WORD_W/8){1'b1}}), LINE_W'(wb_sel));
            end
        end
        ack_seen = wb_ack;
    end

    initial begin : stimulus
        void'($urandom(22225));
        reset     = 1'b1;
        req_valid = 1'b0;
        req_addr  = '0;
        req_slot  = '0;
        req_kind  = REQ_LOAD;
        mem_stall = 1'b0;
        build_table();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compare_value("wake_valid", LINE_W'(1'b0), LINE_W'(wake_valid));
        compare_value("wb_cyc", LINE_W'(1'b0), LINE_W'(wb_cyc));
        compare_value("req_ready", LINE_W'(1'b1), LINE_W'(req_ready));
        finish_test();
        @(posedge clk);
        for (int i = 0; i < rows.size(); i++) begin
            if (!aborted) begin
                test_name = test_names[rows[i].test];
                send_row(rows[i]);
                if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
                    req_valid <= 1'b0;
                    drain_wakes();
                    if (rows[i].test == 5) begin
                        compare_value("placed in wake cycle", LINE_W'(1'b1),
                                      LINE_W'(same_cycle_allocs != 0));
                    end
                    finish_test();
                end
            end
        end
        $display("tests %0d, passed %0d, checks %0d, errors %0d",
                 tests_run, passed, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- tb_wb_mem.sv
module tb_wb_mem
    import miss_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   mem_stall,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [BYTE_ADDR_W-1:0] wb_adr,
    output logic [WORD_W-1:0]      wb_dat_o,
    output logic                   wb_ack
);

    logic       busy;   // the current beat has drawn its delay.
    logic [1:0] delay;

    // every word reads as its byte address times 3 plus 1.
    function automatic logic [WORD_W-1:0] word_at(input logic [BYTE_ADDR_W-1:0] adr);
        return WORD_W'(adr) * 3 + 1;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            delay    <= '0;
            wb_ack   <= 1'b0;
            wb_dat_o <= '0;
        end else begin
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !wb_we && !wb_ack) begin
                if (!busy) begin
                    busy  <= 1'b1;
                    delay <= 2'($urandom % 4);   // 0 to 3 wait cycles.
                end else if (delay != 0) begin
                    delay <= delay - 1'b1;
                end else if (!mem_stall) begin
                    busy     <= 1'b0;
                    wb_ack   <= 1'b1;
                    wb_dat_o <= word_at(wb_adr);
                end
            end
        end
    end

endmodule

//--- miss_unit_top.sv
module miss_unit_top
    import miss_pkg::*;
#(
    parameter int MSHR_DEPTH = 8
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  req_valid,
    input  logic [BYTE_ADDR_W-1:0]                req_addr,
    input  logic [SLOT_IDX_W-1:0]                 req_slot,
    input  req_kind_t                             req_kind,
    output logic                                  req_ready,
    output logic                                  wb_cyc,
    output logic                                  wb_stb,
    output logic                                  wb_we,
    output logic [BYTE_ADDR_W-1:0]                wb_adr,
    output logic [WORD_W/8-1:0]                   wb_sel,
    input  logic [WORD_W-1:0]                     wb_dat_i,
    input  logic                                  wb_ack,
    output logic                                  wake_valid,
    output logic [LINE_ADDR_W-1:0]                wake_addr,
    output logic [WORD_W*(1<<LINE_WORDS_LOG)-1:0] wake_data,
    output logic [SLOT_COUNT-1:0]                 wake_rd_slots,
    output logic [SLOT_COUNT-1:0]                 wake_sw_slots
);

    logic [LINE_ADDR_W-1:0]    look_addr;
    logic                      hit;
    logic                      full;
    logic                      alloc;
    logic                      merge;
    logic [SLOT_COUNT-1:0]     rd_mask;
    logic [SLOT_COUNT-1:0]     sw_mask;
    logic                      dealloc;
    logic                      fetch_start;
    logic                      head_valid;
    logic [LINE_ADDR_W-1:0]    head_addr;
    logic [SLOT_COUNT-1:0]     head_rd_mask;
    logic [SLOT_COUNT-1:0]     head_sw_mask;
    logic                      head_issued;
    logic                      word_valid;
    logic [WORD_W-1:0]         word_data;
    logic [LINE_WORDS_LOG-1:0] word_index;

    miss_intake u_intake (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .req_slot  (req_slot),
        .req_kind  (req_kind),
        .hit       (hit),
        .full      (full),
        .req_ready (req_ready),
        .look_addr (look_addr),
        .alloc     (alloc),
        .merge     (merge),
        .rd_mask   (rd_mask),
        .sw_mask   (sw_mask)
    );

    mshr_file #(
        .MSHR_DEPTH (MSHR_DEPTH)
    ) u_mshr (
        .clk          (clk),
        .reset        (reset),
        .look_addr    (look_addr),
        .alloc        (alloc),
        .merge        (merge),
        .rd_mask      (rd_mask),
        .sw_mask      (sw_mask),
        .dealloc      (dealloc),
        .fetch_start  (fetch_start),
        .hit          (hit),
        .full         (full),
        .head_valid   (head_valid),
        .head_addr    (head_addr),
        .head_rd_mask (head_rd_mask),
        .head_sw_mask (head_sw_mask),
        .head_issued  (head_issued)
    );

    fill_fetcher u_fetch (
        .clk         (clk),
        .reset       (reset),
        .head_valid  (head_valid),
        .head_addr   (head_addr),
        .head_issued (head_issued),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .fetch_start (fetch_start),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_sel      (wb_sel),
        .word_valid  (word_valid),
        .word_data   (word_data),
        .word_index  (word_index)
    );

    fill_return u_return (
        .clk           (clk),
        .reset         (reset),
        .word_valid    (word_valid),
        .word_data     (word_data),
        .word_index    (word_index),
        .head_addr     (head_addr),
        .head_rd_mask  (head_rd_mask),
        .head_sw_mask  (head_sw_mask),
        .dealloc       (dealloc),
        .wake_valid    (wake_valid),
        .wake_addr     (wake_addr),
        .wake_data     (wake_data),
        .wake_rd_slots (wake_rd_slots),
        .wake_sw_slots (wake_sw_slots)
    );

endmodule

//--- fill_return.sv
module fill_return
    import miss_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  word_valid,
    input  logic [WORD_W-1:0]                     word_data,
    input  logic [LINE_WORDS_LOG-1:0]             word_index,
    input  logic [LINE_ADDR_W-1:0]                head_addr,
    input  logic [SLOT_COUNT-1:0]                 head_rd_mask,
    input  logic [SLOT_COUNT-1:0]                 head_sw_mask,
    output logic                                  dealloc,
    output logic                                  wake_valid,
    output logic [LINE_ADDR_W-1:0]                wake_addr,
    output logic [WORD_W*(1<<LINE_WORDS_LOG)-1:0] wake_data,
    output logic [SLOT_COUNT-1:0]                 wake_rd_slots,
    output logic [SLOT_COUNT-1:0]                 wake_sw_slots
);

    localparam int LINE_W = WORD_W * (1 << LINE_WORDS_LOG);

    logic [LINE_W-1:0]      line_buf;
    logic [LINE_ADDR_W-1:0] addr_q;
    logic                   last_word;

    assign last_word = word_valid && (word_index == '1);

    always_ff @(posedge clk) begin
        if (reset) begin
            wake_valid <= 1'b0;
        end else begin
            wake_valid <= last_word;   // one cycle pulse.
        end
    end

    // word 0 in the low bits.
    always_ff @(posedge clk) begin
        if (word_valid) begin
            line_buf[word_index*WORD_W +: WORD_W] <= word_data;
        end
        if (last_word) begin
            addr_q <= head_addr;
        end
    end

    // head entry is still valid in the wake cycle; it leaves on dealloc.
    assign dealloc   = wake_valid;
    assign wake_addr = wake_valid ? addr_q : '0;
    assign wake_data = wake_valid ? line_buf : '0;

    // masks are taken live from the head, so a merge landing on the
    // last beat edge is still carried in this wake.
    assign wake_rd_slots = wake_valid ? head_rd_mask : '0;
    assign wake_sw_slots = wake_valid ? head_sw_mask : '0;

endmodule

//--- fill_fetcher.sv
module fill_fetcher
    import miss_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      head_valid,
    input  logic [LINE_ADDR_W-1:0]    head_addr,
    input  logic                      head_issued,
    input  logic [WORD_W-1:0]         wb_dat_i,
    input  logic                      wb_ack,
    output logic                      fetch_start,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output logic [BYTE_ADDR_W-1:0]    wb_adr,
    output logic [WORD_W/8-1:0]       wb_sel,
    output logic                      word_valid,
    output logic [WORD_W-1:0]         word_data,
    output logic [LINE_WORDS_LOG-1:0] word_index
);

    fetch_state_t              state;
    logic [LINE_ADDR_W-1:0]    line_q;
    logic [LINE_WORDS_LOG-1:0] beat;
    logic                      bus_act;   // one classic read in progress.

    assign fetch_start = (state == FETCH_IDLE) && head_valid && !head_issued;

    assign wb_cyc = bus_act;
    assign wb_stb = bus_act;
    assign wb_we  = 1'b0;
    assign wb_sel = '1;
    assign wb_adr = {line_q, beat, 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= FETCH_IDLE;
            bus_act    <= 1'b0;
            beat       <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            case (state)
                FETCH_IDLE: begin
                    if (fetch_start) begin
                        state   <= FETCH_BUS;
                        bus_act <= 1'b1;
                        beat    <= '0;
                    end
                end
                FETCH_BUS: begin
                    if (bus_act && wb_ack) begin
                        bus_act    <= 1'b0;   // stb low at least one cycle.
                        word_valid <= 1'b1;
                        if (beat == '1) begin
                            state <= FETCH_DONE;
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end else if (!bus_act) begin
                        bus_act <= 1'b1;   // next beat.
                    end
                end
                FETCH_DONE: begin
                    state <= FETCH_IDLE;   // head stays issued until its wake.
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // latched line and returned word.
    always_ff @(posedge clk) begin
        if (fetch_start) begin
            line_q <= head_addr;
        end
        if (bus_act && wb_ack) begin
            word_data  <= wb_dat_i;
            word_index <= beat;
        end
    end

endmodule

//--- mshr_file.sv
module mshr_file
    import miss_pkg::*;
#(
    parameter int MSHR_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [LINE_ADDR_W-1:0] look_addr,
    input  logic                   alloc,
    input  logic                   merge,
    input  logic [SLOT_COUNT-1:0]  rd_mask,
    input  logic [SLOT_COUNT-1:0]  sw_mask,
    input  logic                   dealloc,
    input  logic                   fetch_start,
    output logic                   hit,
    output logic                   full,
    output logic                   head_valid,
    output logic [LINE_ADDR_W-1:0] head_addr,
    output logic [SLOT_COUNT-1:0]  head_rd_mask,
    output logic [SLOT_COUNT-1:0]  head_sw_mask,
    output logic                   head_issued
);

    localparam int PTR_W = (MSHR_DEPTH > 1) ? $clog2(MSHR_DEPTH) : 1;
    localparam int CNT_W = $clog2(MSHR_DEPTH + 1);

    logic [MSHR_DEPTH-1:0]  ent_valid;
    logic [MSHR_DEPTH-1:0]  ent_issued;
    logic [LINE_ADDR_W-1:0] ent_addr [MSHR_DEPTH];
    logic [SLOT_COUNT-1:0]  ent_rd   [MSHR_DEPTH];
    logic [SLOT_COUNT-1:0]  ent_sw   [MSHR_DEPTH];

    logic [PTR_W-1:0]       head;
    logic [PTR_W-1:0]       tail;
    logic [CNT_W-1:0]       count;
    logic [MSHR_DEPTH-1:0]  hit_vec;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(MSHR_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // the head leaving this cycle no longer counts as a match.
    always_comb begin
        for (int i = 0; i < MSHR_DEPTH; i++) begin
            hit_vec[i] = ent_valid[i] && (ent_addr[i] == look_addr)
                         && !(dealloc && (head == PTR_W'(i)));
        end
    end

    assign hit  = |hit_vec;
    assign full = (count == CNT_W'(MSHR_DEPTH));

    assign head_valid   = ent_valid[head];
    assign head_addr    = ent_addr[head];
    assign head_rd_mask = ent_rd[head];
    assign head_sw_mask = ent_sw[head];
    assign head_issued  = ent_issued[head];

    always_ff @(posedge clk) begin
        if (reset) begin
            ent_valid  <= '0;
            ent_issued <= '0;
            head       <= '0;
            tail       <= '0;
            count      <= '0;
        end else begin
            if (fetch_start) begin
                ent_issued[head] <= 1'b1;
            end
            if (dealloc) begin
                ent_valid[head]  <= 1'b0;
                ent_issued[head] <= 1'b0;
                head             <= next_ptr(head);
            end
            // alloc is never raised when full, so tail and head differ here.
            if (alloc) begin
                ent_valid[tail]  <= 1'b1;
                ent_issued[tail] <= 1'b0;
                tail             <= next_ptr(tail);
            end
            case ({alloc, dealloc})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // line address and waiter masks.
    always_ff @(posedge clk) begin
        if (alloc) begin
            ent_addr[tail] <= look_addr;
            ent_rd[tail]   <= rd_mask;
            ent_sw[tail]   <= sw_mask;
        end
        for (int i = 0; i < MSHR_DEPTH; i++) begin
            if (merge && hit_vec[i]) begin
                ent_rd[i] <= ent_rd[i] | rd_mask;   // new waiter joins the line.
                ent_sw[i] <= ent_sw[i] | sw_mask;
            end
        end
    end

endmodule

//--- miss_intake.sv
module miss_intake
    import miss_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req_valid,
    input  logic [BYTE_ADDR_W-1:0] req_addr,
    input  logic [SLOT_IDX_W-1:0]  req_slot,
    input  req_kind_t              req_kind,
    input  logic                   hit,
    input  logic                   full,
    output logic                   req_ready,
    output logic [LINE_ADDR_W-1:0] look_addr,
    output logic                   alloc,
    output logic                   merge,
    output logic [SLOT_COUNT-1:0]  rd_mask,
    output logic [SLOT_COUNT-1:0]  sw_mask
);

    logic                   held_valid;
    logic [LINE_ADDR_W-1:0] held_line;
    logic [SLOT_COUNT-1:0]  held_rd;
    logic [SLOT_COUNT-1:0]  held_sw;
    logic [SLOT_COUNT-1:0]  slot_onehot;
    logic                   place;
    logic                   take;

    assign slot_onehot = SLOT_COUNT'(1) << req_slot;

    // a held miss is placed by merging on a hit, else by a free entry.
    assign place     = held_valid && (hit || !full);
    assign req_ready = !held_valid || place;
    assign take      = req_valid && req_ready;

    assign merge     = held_valid && hit;
    assign alloc     = held_valid && !hit && !full;
    assign look_addr = held_line;
    assign rd_mask   = held_rd;
    assign sw_mask   = held_sw;

    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (take) begin
            held_valid <= 1'b1;
        end else if (place) begin
            held_valid <= 1'b0;   // stall retries every cycle until placed.
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            held_line <= req_addr[BYTE_ADDR_W-1 -: LINE_ADDR_W];
            held_rd   <= (req_kind == REQ_LOAD) ? slot_onehot : '0;
            held_sw   <= (req_kind == REQ_STORE) ? slot_onehot : '0;
        end
    end

endmodule

//--- miss_pkg.sv
package miss_pkg;

    // 15-bit byte address split into 16-byte lines.
    localparam int BYTE_ADDR_W = 15;
    localparam int LINE_ADDR_W = 11;   // byte address bits 14:4.

    // load queue and store queue slots.
    localparam int SLOT_COUNT = 8;
    localparam int SLOT_IDX_W = 3;

    // memory side data.
    localparam int WORD_W = 32;
    localparam int LINE_WORDS_LOG = 2;  // four words per line.

    // which mask a waiter joins.
    typedef enum logic {
        REQ_LOAD  = 1'b0,
        REQ_STORE = 1'b1
    } req_kind_t;

    // fill fetch sequencing.
    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,
        FETCH_BUS  = 2'd1,
        FETCH_DONE = 2'd2
    } fetch_state_t;

endpackage
